// ==== dv/armv4_cases.txt ====
# test <name> <word count>, then the program words in hex.
# stores <count>, then the expected address and data pairs in hex.
# every data-processing opcode with immediate operands.
test dp_imm 18
e3a0cc01 e3a0000f e200103c e22020ff e2403005 e2604020
e2805071 e3806030 e3c07006 e3e08000 e58c1000 e58c2004
e58c3008 e58c400c e58c5010 e58c6014 e58c7018 e58c801c
stores 8
100 0000000c 104 000000f0 108 0000000a 10c 00000011
110 00000080 114 0000003f 118 00000009 11c ffffffff
# cmp and adds, then conditional movs.
test flags_cond 23
e3a0cc01 e3a00005 e3500005 03a02001 13a03001 23a04001
43a05001 e3e07102 e2978001 63a09001 a3a0a001 c3a0b001
d3a01001 43a05002 e58c2000 e58c3004 e58c4008 e58c500c
e58c8010 e58c9014 e58ca018 e58cb01c e58c1020
stores 9
100 00000001 104 00000000 108 00000001 10c 00000002
110 80000000 114 00000001 118 00000001 11c 00000001
120 00000000
# register operands at distance one and two.
test forward 25
e3a0cc01 e3a00003 e0801000 e0812000 e0423001 e58c3000
e0634002 e58c4004 e1845000 e1a06005 e58c6008 e0067002
e1c28006 e1e09008 e58c700c e58c9010 e58c8014 e029a008
e58ca018 e1100001 13a0b005 e58cb01c e1500000 03a0b006
e58cb020
stores 9
100 00000003 104 00000006 108 00000007 10c 00000001
110 fffffff7 114 00000008 118 ffffffff 11c 00000005
120 00000006
# up and down offsets.
test store_ofs 7
e3a0cc01 e3a000ab e58c0010 e50c0010 e3a0bc02 e58bbffc
e50bc1fc
stores 4
110 000000ab 0f0 000000ab 11fc 00000200 004 00000100
# rotated immediates, an ldr and a shifted add run as no-ops.
test rot_imm_ldr 10
e3a0cc01 e3a004ff e3a01e3f e3a021ff e58c0000 e59c0000
e58c1004 e0800081 e58c0008 e58c200c
stores 4
100 ff000000 104 000003f0 108 ff000000 10c c000003f

// ==== list.f ====
hdl/armv4_pkg.sv
hdl/alu.sv
hdl/register_file.sv
hdl/fetch_decode.sv
hdl/id_ex.sv
hdl/ex_stage.sv
hdl/armv4core.sv
dv/tb_armv4core.sv

// ==== dv/tb_armv4core.sv ====
`timescale 1ns/1ps

module tb_armv4core;
    localparam int          ROM_WORDS = 64;
    localparam logic [31:0] NOP_WORD  = 32'hF000_0000;
    localparam logic [1:0]  WORD_SIZE = 2'b10;

    logic        clk;
    logic        i_rst_n;
    logic        i_en;
    logic        o_rom_en;
    logic [31:0] o_rom_addr;
    logic [31:0] i_rom_data;
    logic        o_ram_en;
    logic        o_ram_wr;
    logic [1:0]  o_ram_size;
    logic [31:0] o_ram_addr;
    logic [31:0] o_ram_wdata;

    logic [31:0]     rom [ROM_WORDS];
    logic [31:0]     rom_word;
    logic [31:0]     exp_pc;
    logic [8*32-1:0] test_names [$];
    logic [31:0]     prog [$];
    int              prog_start [$];
    int              prog_len [$];
    logic [31:0]     exp_addr [$];
    logic [31:0]     exp_data [$];
    int              st_start [$];
    int              st_len [$];

    int cur_test;
    int cur_len;
    int cur_st_start;
    int cur_st_len;
    int st_seen;
    int cycles;
    int cycle_limit;

    armv4core #(
        .RESET_PC(32'h0)
    ) DUT (
        .clk(clk), .i_rst_n(i_rst_n), .i_en(i_en),
        .o_rom_en(o_rom_en), .o_rom_addr(o_rom_addr), .i_rom_data(i_rom_data),
        .o_ram_en(o_ram_en), .o_ram_wr(o_ram_wr), .o_ram_size(o_ram_size),
        .o_ram_addr(o_ram_addr), .o_ram_wdata(o_ram_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "stopping at the first error");
    endtask

    // synchronous rom, word appears the cycle after its address.
    always @(posedge clk) begin
        if (o_rom_en) begin
            if (o_rom_addr[31:2] < cur_len) begin
                rom_word = rom[o_rom_addr[7:2]];
            end else begin
                rom_word = NOP_WORD;
            end
            #2;
            i_rom_data = rom_word;
        end
    end

    always @(posedge clk) begin
        if (i_rst_n) begin
            cycles++;
            if (cycles > cycle_limit) begin
                $display("timeout after %0d cycles in test %0s", cycle_limit,
                         test_names[cur_test]);
                abort_run();
            end
        end
    end

    // store bus is combinational off the execute stage.
    always @(negedge clk) begin
        int idx;
        if (!i_rst_n) begin
            exp_pc = '0;
        end else begin
            assert (o_rom_en) else begin
                $display("fetch enable dropped in test %0s", test_names[cur_test]);
                abort_run();
            end
            assert (o_rom_addr == exp_pc) else begin
                $display("ERR %0s fetch address expected %h actual %h",
                         test_names[cur_test], exp_pc, o_rom_addr);
                abort_run();
            end
            exp_pc += 32'd4;
        end
        if (i_rst_n && (o_ram_en || o_ram_wr)) begin
            assert (o_ram_en && o_ram_wr) else begin
                $display("test %0s raised only one of o_ram_en and o_ram_wr",
                         test_names[cur_test]);
                abort_run();
            end
            assert (st_seen < cur_st_len) else begin
                $display("test %0s made an unexpected store to %h", test_names[cur_test],
                         o_ram_addr);
                abort_run();
            end
            idx = cur_st_start + st_seen;
            assert (o_ram_addr == exp_addr[idx]) else begin
                $display("ERR %0s store %0d addr expected %h actual %h",
                         test_names[cur_test], st_seen, exp_addr[idx], o_ram_addr);
                abort_run();
            end
            assert (o_ram_wdata == exp_data[idx]) else begin
                $display("ERR %0s store %0d data expected %h actual %h",
                         test_names[cur_test], st_seen, exp_data[idx], o_ram_wdata);
                abort_run();
            end
            assert (o_ram_size == WORD_SIZE) else begin
                $display("ERR %0s store %0d size expected %h actual %h",
                         test_names[cur_test], st_seen, WORD_SIZE, o_ram_size);
                abort_run();
            end
            st_seen++;
        end
    end

    task automatic read_cases();
        int               fd;
        int               rc;
        int               n;
        logic [8*32-1:0]  tok;
        logic [8*32-1:0]  name;
        logic [8*128-1:0] line_buf;
        logic [31:0]      a;
        logic [31:0]      w;
        fd = $fopen("dv/armv4_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open dv/armv4_cases.txt");
            abort_run();
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                rc = $fgets(line_buf, fd);
            end else if (tok == "test") begin
                rc = $fscanf(fd, "%s %d", name, n);
                if (rc != 2 || n < 1 || n > ROM_WORDS) begin
                    $display("bad test header after %0d tests", test_names.size());
                    abort_run();
                end
                test_names.push_back(name);
                prog_start.push_back(prog.size());
                prog_len.push_back(n);
                repeat (n) begin
                    rc = $fscanf(fd, "%h", w);
                    prog.push_back(w);
                end
            end else if (tok == "stores") begin
                rc = $fscanf(fd, "%d", n);
                st_start.push_back(exp_addr.size());
                st_len.push_back(n);
                repeat (n) begin
                    rc = $fscanf(fd, "%h %h", a, w);
                    exp_addr.push_back(a);
                    exp_data.push_back(w);
                end
            end else begin
                $display("unknown token %0s in the case file", tok);
                abort_run();
            end
        end
        $fclose(fd);
        if (test_names.size() == 0 || st_len.size() != test_names.size()) begin
            $display("case file holds no complete test");
            abort_run();
        end
    endtask

    task automatic run_test(input int t);
        i_rst_n      = 1'b0;
        cur_test     = t;
        cur_len      = prog_len[t];
        cur_st_start = st_start[t];
        cur_st_len   = st_len[t];
        st_seen      = 0;
        for (int k = 0; k < ROM_WORDS; k++) begin
            rom[k] = (k < cur_len) ? prog[prog_start[t] + k] : NOP_WORD;
        end
        repeat (16) @(posedge clk);
        #2;
        i_rst_n = 1'b1;
        // last word is fetched once the pc runs past the program.
        do begin
            @(posedge clk);
            #2;
        end while (o_rom_addr != 32'(cur_len * 4));
        repeat (8) @(posedge clk);
        #2;
        assert (st_seen == cur_st_len) else begin
            $display("ERR %0s store count expected %0d actual %0d", test_names[t],
                     cur_st_len, st_seen);
            abort_run();
        end
    endtask

    initial begin
        i_rst_n      = 1'b0;
        i_en         = 1'b1;
        i_rom_data   = NOP_WORD;
        rom_word     = NOP_WORD;
        exp_pc       = '0;
        cur_test     = 0;
        cur_len      = 0;
        cur_st_start = 0;
        cur_st_len   = 0;
        st_seen      = 0;
        cycles       = 0;
        cycle_limit  = 0;
        read_cases();
        cycle_limit = prog.size() + 24 * test_names.size();
        for (int t = 0; t < test_names.size(); t++) begin
            run_test(t);
        end
        $display("Regression passed");
        $finish;
    end
endmodule

// ==== hdl/armv4core.sv ====
`timescale 1ns/1ps

module armv4core #(
    parameter logic [armv4_pkg::WORD_W-1:0] RESET_PC = armv4_pkg::RESET_PC_DEFAULT
) (
    input  logic                         clk,
    input  logic                         i_rst_n,
    input  logic                         i_en,
    output logic                         o_rom_en,
    output logic [armv4_pkg::WORD_W-1:0] o_rom_addr,
    input  logic [armv4_pkg::WORD_W-1:0] i_rom_data,
    output logic                         o_ram_en,
    output logic                         o_ram_wr,
    output logic [1:0]                   o_ram_size,
    output logic [armv4_pkg::WORD_W-1:0] o_ram_addr,
    output logic [armv4_pkg::WORD_W-1:0] o_ram_wdata
);
    logic [armv4_pkg::REG_CODE_W-1:0] rn_code, rm_code;
    logic [armv4_pkg::WORD_W-1:0]     rn_reg, rm_reg;
    logic                             fw_ex_rd_en, wb_rd_en;
    logic [armv4_pkg::REG_CODE_W-1:0] fw_ex_rd_code, wb_rd_code;
    logic [armv4_pkg::WORD_W-1:0]     fw_ex_rd_reg, wb_rd_reg;

    // decoded fields, before and after the pipeline register.
    logic                             dec_vld, ex_vld;
    armv4_pkg::cond_e                 dec_cond, ex_cond;
    armv4_pkg::opcode_e               dec_opcode, ex_opcode;
    logic                             dec_set_flags, ex_set_flags;
    logic                             dec_is_store, ex_is_store;
    logic                             dec_store_up, ex_store_up;
    logic [armv4_pkg::WORD_W-1:0]     dec_op1, dec_op2, dec_store_data;
    logic [armv4_pkg::WORD_W-1:0]     ex_op1, ex_op2, ex_store_data;
    logic                             dec_rd_vld, ex_rd_vld;
    logic [armv4_pkg::REG_CODE_W-1:0] dec_rd_code, ex_rd_code;

    fetch_decode #(
        .RESET_PC(RESET_PC)
    ) u_fetch_decode (
        .clk(clk), .i_rst_n(i_rst_n), .i_en(i_en),
        .i_rom_data(i_rom_data), .o_rom_en(o_rom_en), .o_rom_addr(o_rom_addr),
        .o_rn_code(rn_code), .o_rm_code(rm_code), .i_rn_reg(rn_reg), .i_rm_reg(rm_reg),
        .i_ex_rd_en(fw_ex_rd_en), .i_ex_rd_code(fw_ex_rd_code), .i_ex_rd_reg(fw_ex_rd_reg),
        .i_wb_rd_en(wb_rd_en), .i_wb_rd_code(wb_rd_code), .i_wb_rd_reg(wb_rd_reg),
        .o_vld(dec_vld), .o_cond(dec_cond), .o_opcode(dec_opcode),
        .o_set_flags(dec_set_flags), .o_is_store(dec_is_store), .o_store_up(dec_store_up),
        .o_op1(dec_op1), .o_op2(dec_op2), .o_store_data(dec_store_data),
        .o_rd_vld(dec_rd_vld), .o_rd_code(dec_rd_code)
    );

    register_file u_register_file (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_rn_code(rn_code), .i_rm_code(rm_code),
        .i_wr_en(wb_rd_en), .i_wr_code(wb_rd_code), .i_wr_reg(wb_rd_reg),
        .o_rn_reg(rn_reg), .o_rm_reg(rm_reg)
    );

    id_ex u_id_ex (
        .clk(clk), .i_rst_n(i_rst_n), .i_en(i_en),
        .i_vld(dec_vld), .i_cond(dec_cond), .i_opcode(dec_opcode),
        .i_set_flags(dec_set_flags), .i_is_store(dec_is_store), .i_store_up(dec_store_up),
        .i_op1(dec_op1), .i_op2(dec_op2), .i_store_data(dec_store_data),
        .i_rd_vld(dec_rd_vld), .i_rd_code(dec_rd_code),
        .o_vld(ex_vld), .o_cond(ex_cond), .o_opcode(ex_opcode),
        .o_set_flags(ex_set_flags), .o_is_store(ex_is_store), .o_store_up(ex_store_up),
        .o_op1(ex_op1), .o_op2(ex_op2), .o_store_data(ex_store_data),
        .o_rd_vld(ex_rd_vld), .o_rd_code(ex_rd_code)
    );

    ex_stage u_ex_stage (
        .clk(clk), .i_rst_n(i_rst_n), .i_en(i_en),
        .i_vld(ex_vld), .i_cond(ex_cond), .i_opcode(ex_opcode),
        .i_set_flags(ex_set_flags), .i_is_store(ex_is_store), .i_store_up(ex_store_up),
        .i_op1(ex_op1), .i_op2(ex_op2), .i_store_data(ex_store_data),
        .i_rd_vld(ex_rd_vld), .i_rd_code(ex_rd_code),
        .o_ex_rd_en(fw_ex_rd_en), .o_ex_rd_code(fw_ex_rd_code), .o_ex_rd_reg(fw_ex_rd_reg),
        .o_wb_rd_en(wb_rd_en), .o_wb_rd_code(wb_rd_code), .o_wb_rd_reg(wb_rd_reg),
        .o_ram_en(o_ram_en), .o_ram_wr(o_ram_wr), .o_ram_size(o_ram_size),
        .o_ram_addr(o_ram_addr), .o_ram_wdata(o_ram_wdata)
    );
endmodule

// ==== hdl/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage (
    input  logic                             clk,
    input  logic                             i_rst_n,
    input  logic                             i_en,
    input  logic                             i_vld,
    input  armv4_pkg::cond_e                 i_cond,
    input  armv4_pkg::opcode_e               i_opcode,
    input  logic                             i_set_flags, i_is_store, i_store_up,
    input  logic [armv4_pkg::WORD_W-1:0]     i_op1, i_op2, i_store_data,
    input  logic                             i_rd_vld,
    input  logic [armv4_pkg::REG_CODE_W-1:0] i_rd_code,
    output logic                             o_ex_rd_en,
    output logic [armv4_pkg::REG_CODE_W-1:0] o_ex_rd_code,
    output logic [armv4_pkg::WORD_W-1:0]     o_ex_rd_reg,
    output logic                             o_wb_rd_en,
    output logic [armv4_pkg::REG_CODE_W-1:0] o_wb_rd_code,
    output logic [armv4_pkg::WORD_W-1:0]     o_wb_rd_reg,
    output logic                             o_ram_en,
    output logic                             o_ram_wr,
    output logic [1:0]                       o_ram_size,
    output logic [armv4_pkg::WORD_W-1:0]     o_ram_addr,
    output logic [armv4_pkg::WORD_W-1:0]     o_ram_wdata
);
    logic [armv4_pkg::NZCV_W-1:0] nzcv;
    logic [armv4_pkg::NZCV_W-1:0] alu_nzcv;
    logic [armv4_pkg::WORD_W-1:0] alu_result;
    logic                         alu_writes_rd;
    logic                         n, z, c, v;
    logic                         cond_pass;
    logic                         exec;

    alu u_alu (
        .i_opcode    (i_opcode),
        .i_op1       (i_op1),
        .i_op2       (i_op2),
        .i_nzcv      (nzcv),
        .o_result    (alu_result),
        .o_nzcv      (alu_nzcv),
        .o_writes_rd (alu_writes_rd)
    );

    assign {n, z, c, v} = nzcv;

    always_comb begin
        case (i_cond)
            armv4_pkg::EQ: cond_pass = z;
            armv4_pkg::NE: cond_pass = !z;
            armv4_pkg::CS: cond_pass = c;
            armv4_pkg::CC: cond_pass = !c;
            armv4_pkg::MI: cond_pass = n;
            armv4_pkg::PL: cond_pass = !n;
            armv4_pkg::VS: cond_pass = v;
            armv4_pkg::VC: cond_pass = !v;
            armv4_pkg::HI: cond_pass = c && !z;
            armv4_pkg::LS: cond_pass = !c || z;
            armv4_pkg::GE: cond_pass = (n == v);
            armv4_pkg::LT: cond_pass = (n != v);
            armv4_pkg::GT: cond_pass = !z && (n == v);
            armv4_pkg::LE: cond_pass = z || (n != v);
            armv4_pkg::AL: cond_pass = 1'b1;
            default:       cond_pass = 1'b0;
        endcase
    end

    assign exec = i_vld && cond_pass;

    assign o_ex_rd_en   = exec && i_rd_vld && alu_writes_rd;
    assign o_ex_rd_code = i_rd_code;
    assign o_ex_rd_reg  = alu_result;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            nzcv       <= '0;
            o_wb_rd_en <= 1'b0;
        end else if (i_en) begin
            if (exec && i_set_flags) begin
                nzcv <= alu_nzcv;
            end
            o_wb_rd_en <= o_ex_rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (i_en) begin
            o_wb_rd_code <= o_ex_rd_code;
            o_wb_rd_reg  <= o_ex_rd_reg;
        end
    end

    // pre-indexed word store, base left unchanged.
    assign o_ram_en    = i_en && exec && i_is_store;
    assign o_ram_wr    = o_ram_en;
    assign o_ram_size  = 2'b10;
    assign o_ram_addr  = i_store_up ? i_op1 + i_op2 : i_op1 - i_op2;
    assign o_ram_wdata = i_store_data;
endmodule

// ==== hdl/id_ex.sv ====
`timescale 1ns/1ps

module id_ex (
    input  logic                             clk,
    input  logic                             i_rst_n,
    input  logic                             i_en,
    input  logic                             i_vld,
    input  armv4_pkg::cond_e                 i_cond,
    input  armv4_pkg::opcode_e               i_opcode,
    input  logic                             i_set_flags, i_is_store, i_store_up,
    input  logic [armv4_pkg::WORD_W-1:0]     i_op1, i_op2, i_store_data,
    input  logic                             i_rd_vld,
    input  logic [armv4_pkg::REG_CODE_W-1:0] i_rd_code,
    output logic                             o_vld,
    output armv4_pkg::cond_e                 o_cond,
    output armv4_pkg::opcode_e               o_opcode,
    output logic                             o_set_flags, o_is_store, o_store_up,
    output logic [armv4_pkg::WORD_W-1:0]     o_op1, o_op2, o_store_data,
    output logic                             o_rd_vld,
    output logic [armv4_pkg::REG_CODE_W-1:0] o_rd_code
);
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_vld <= 1'b0;
        end else if (i_en) begin
            o_vld <= i_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (i_en) begin
            o_cond       <= i_cond;
            o_opcode     <= i_opcode;
            o_set_flags  <= i_set_flags;
            o_is_store   <= i_is_store;
            o_store_up   <= i_store_up;
            o_op1        <= i_op1;
            o_op2        <= i_op2;
            o_store_data <= i_store_data;
            o_rd_vld     <= i_rd_vld;
            o_rd_code    <= i_rd_code;
        end
    end
endmodule

// ==== hdl/fetch_decode.sv ====
`timescale 1ns/1ps

module fetch_decode #(
    parameter logic [armv4_pkg::WORD_W-1:0] RESET_PC = armv4_pkg::RESET_PC_DEFAULT
) (
    input  logic                             clk,
    input  logic                             i_rst_n,
    input  logic                             i_en,
    input  logic [armv4_pkg::WORD_W-1:0]     i_rom_data,
    output logic                             o_rom_en,
    output logic [armv4_pkg::WORD_W-1:0]     o_rom_addr,
    output logic [armv4_pkg::REG_CODE_W-1:0] o_rn_code,
    output logic [armv4_pkg::REG_CODE_W-1:0] o_rm_code,
    input  logic [armv4_pkg::WORD_W-1:0]     i_rn_reg,
    input  logic [armv4_pkg::WORD_W-1:0]     i_rm_reg,
    input  logic                             i_ex_rd_en,
    input  logic [armv4_pkg::REG_CODE_W-1:0] i_ex_rd_code,
    input  logic [armv4_pkg::WORD_W-1:0]     i_ex_rd_reg,
    input  logic                             i_wb_rd_en,
    input  logic [armv4_pkg::REG_CODE_W-1:0] i_wb_rd_code,
    input  logic [armv4_pkg::WORD_W-1:0]     i_wb_rd_reg,
    output logic                             o_vld,
    output armv4_pkg::cond_e                 o_cond,
    output armv4_pkg::opcode_e               o_opcode,
    output logic                             o_set_flags, o_is_store, o_store_up,
    output logic [armv4_pkg::WORD_W-1:0]     o_op1, o_op2, o_store_data,
    output logic                             o_rd_vld,
    output logic [armv4_pkg::REG_CODE_W-1:0] o_rd_code
);
    logic [armv4_pkg::WORD_W-1:0]   pc;
    logic                           fetch_vld;
    armv4_pkg::arm_inst_u           inst;
    logic                           dp_op_ok;
    logic                           is_dp;
    logic                           is_store;
    logic [2*armv4_pkg::WORD_W-1:0] imm_rot;
    logic [armv4_pkg::WORD_W-1:0]   rn_fwd;
    logic [armv4_pkg::WORD_W-1:0]   rm_fwd;

    function automatic logic [armv4_pkg::WORD_W-1:0] fwd(
        input logic [armv4_pkg::REG_CODE_W-1:0] code,
        input logic [armv4_pkg::WORD_W-1:0]     rf_val
    );
        if (i_ex_rd_en && i_ex_rd_code == code) begin
            return i_ex_rd_reg;
        end else if (i_wb_rd_en && i_wb_rd_code == code) begin
            return i_wb_rd_reg;
        end
        return rf_val;
    endfunction

    // no word is on i_rom_data until the first address was sampled.
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc        <= RESET_PC;
            fetch_vld <= 1'b0;
        end else if (i_en) begin
            pc        <= pc + 32'd4;
            fetch_vld <= 1'b1;
        end
    end

    assign o_rom_en   = i_en;
    assign o_rom_addr = pc;
    assign inst       = i_rom_data;

    // TST and CMP with S clear belong to other classes.
    always_comb begin
        case (inst.dp.opcode)
            armv4_pkg::TST,
            armv4_pkg::CMP: dp_op_ok = inst.dp.s;
            armv4_pkg::AND, armv4_pkg::EOR, armv4_pkg::SUB, armv4_pkg::RSB,
            armv4_pkg::ADD, armv4_pkg::ORR, armv4_pkg::MOV, armv4_pkg::BIC,
            armv4_pkg::MVN: dp_op_ok = (inst.dp.rd != 4'hF);
            default: dp_op_ok = 1'b0;
        endcase
    end

    assign is_dp    = (inst.dp.fixed == 2'b00) && dp_op_ok
                   && (inst.dp.imm || inst.dp.operand2[11:4] == 8'h00);
    assign is_store = (inst.mem.fixed == 2'b01) && !inst.mem.reg_ofs && inst.mem.p
                   && !inst.mem.b && !inst.mem.w && !inst.mem.l;
    assign o_vld    = fetch_vld && (inst.dp.cond != 4'hF) && (is_dp || is_store);

    assign o_rn_code = inst.dp.rn;
    // store source goes through the rm port.
    assign o_rm_code = is_store ? inst.mem.rd : inst.dp.operand2[3:0];

    always_comb begin
        rn_fwd = fwd(o_rn_code, i_rn_reg);
        rm_fwd = fwd(o_rm_code, i_rm_reg);
    end

    // ror by twice the rotate field.
    assign imm_rot = {2{{24'h0, inst.dp.operand2[7:0]}}} >> {inst.dp.operand2[11:8], 1'b0};

    assign o_cond       = armv4_pkg::cond_e'(inst.dp.cond);
    assign o_opcode     = armv4_pkg::opcode_e'(inst.dp.opcode);
    assign o_set_flags  = is_dp && inst.dp.s;
    assign o_is_store   = is_store;
    assign o_store_up   = inst.mem.u;
    assign o_op1        = rn_fwd;
    assign o_op2        = is_store    ? {20'h0, inst.mem.offset} :
                          inst.dp.imm ? imm_rot[armv4_pkg::WORD_W-1:0] : rm_fwd;
    assign o_store_data = rm_fwd;
    assign o_rd_vld     = is_dp;
    assign o_rd_code    = inst.dp.rd;
endmodule

// ==== hdl/register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic                             clk,
    input  logic                             i_rst_n,
    input  logic [armv4_pkg::REG_CODE_W-1:0] i_rn_code,
    input  logic [armv4_pkg::REG_CODE_W-1:0] i_rm_code,
    input  logic                             i_wr_en,
    input  logic [armv4_pkg::REG_CODE_W-1:0] i_wr_code,
    input  logic [armv4_pkg::WORD_W-1:0]     i_wr_reg,
    output logic [armv4_pkg::WORD_W-1:0]     o_rn_reg,
    output logic [armv4_pkg::WORD_W-1:0]     o_rm_reg
);
    // r0 to r14 only.
    logic [armv4_pkg::WORD_W-1:0] regs [15];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 15; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && i_wr_code != 4'hF) begin
            regs[i_wr_code] <= i_wr_reg;
        end
    end

    assign o_rn_reg = (i_rn_code == 4'hF) ? '0 : regs[i_rn_code];
    assign o_rm_reg = (i_rm_code == 4'hF) ? '0 : regs[i_rm_code];
endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  armv4_pkg::opcode_e           i_opcode,
    input  logic [armv4_pkg::WORD_W-1:0] i_op1,
    input  logic [armv4_pkg::WORD_W-1:0] i_op2,
    input  logic [armv4_pkg::NZCV_W-1:0] i_nzcv,
    output logic [armv4_pkg::WORD_W-1:0] o_result,
    output logic [armv4_pkg::NZCV_W-1:0] o_nzcv,
    output logic                         o_writes_rd
);
    localparam int MSB = armv4_pkg::WORD_W - 1;

    logic [MSB:0]   add_a;
    logic [MSB:0]   add_b;
    logic           add_cin;
    logic [MSB+1:0] sum;
    logic           arith;

    // subtract as a + ~b + 1.
    always_comb begin
        add_a   = i_op1;
        add_b   = ~i_op2;
        add_cin = 1'b1;
        if (i_opcode == armv4_pkg::RSB) begin
            add_a = i_op2;
            add_b = ~i_op1;
        end else if (i_opcode == armv4_pkg::ADD) begin
            add_b   = i_op2;
            add_cin = 1'b0;
        end
    end

    assign sum = {1'b0, add_a} + {1'b0, add_b} + add_cin;

    always_comb begin
        arith       = 1'b0;
        o_writes_rd = 1'b1;
        case (i_opcode)
            armv4_pkg::AND: o_result = i_op1 & i_op2;
            armv4_pkg::EOR: o_result = i_op1 ^ i_op2;
            armv4_pkg::ORR: o_result = i_op1 | i_op2;
            armv4_pkg::MOV: o_result = i_op2;
            armv4_pkg::BIC: o_result = i_op1 & ~i_op2;
            armv4_pkg::MVN: o_result = ~i_op2;
            armv4_pkg::TST: begin
                o_result    = i_op1 & i_op2;
                o_writes_rd = 1'b0;
            end
            armv4_pkg::CMP: begin
                o_result    = sum[MSB:0];
                arith       = 1'b1;
                o_writes_rd = 1'b0;
            end
            default: begin
                // sub, rsb and add.
                o_result = sum[MSB:0];
                arith    = 1'b1;
            end
        endcase
    end

    assign o_nzcv[3] = o_result[MSB];
    assign o_nzcv[2] = (o_result == '0);
    // logical ops keep C and V.
    assign o_nzcv[1] = arith ? sum[MSB+1] : i_nzcv[1];
    assign o_nzcv[0] = arith ? (add_a[MSB] == add_b[MSB]) && (sum[MSB] != add_a[MSB])
                             : i_nzcv[0];
endmodule

// ==== hdl/armv4_pkg.sv ====
package armv4_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_CODE_W = 4;
    localparam int NZCV_W     = 4;

    localparam logic [WORD_W-1:0] RESET_PC_DEFAULT = '0;

    // kept data-processing opcodes.
    typedef enum logic [3:0] {
        AND = 4'h0,
        EOR = 4'h1,
        SUB = 4'h2,
        RSB = 4'h3,
        ADD = 4'h4,
        TST = 4'h8,
        CMP = 4'hA,
        ORR = 4'hC,
        MOV = 4'hD,
        BIC = 4'hE,
        MVN = 4'hF
    } opcode_e;

    typedef enum logic [3:0] {
        EQ, NE, CS, CC, MI, PL, VS, VC, HI, LS, GE, LT, GT, LE, AL
    } cond_e;

    typedef union packed {
        struct packed {
            logic [3:0]            cond;
            // 2'b00 for data-processing.
            logic [1:0]            fixed;
            logic                  imm;
            logic [3:0]            opcode;
            logic                  s;
            logic [REG_CODE_W-1:0] rn;
            logic [REG_CODE_W-1:0] rd;
            logic [11:0]           operand2;
        } dp;
        struct packed {
            logic [3:0]            cond;
            // 2'b01 for single transfers.
            logic [1:0]            fixed;
            // low when the offset is an immediate.
            logic                  reg_ofs;
            logic                  p;
            logic                  u;
            logic                  b;
            logic                  w;
            logic                  l;
            logic [REG_CODE_W-1:0] rn;
            logic [REG_CODE_W-1:0] rd;
            logic [11:0]           offset;
        } mem;
    } arm_inst_u;

endpackage
